// ==== Makefile ====
# Verilator build and run for the board control logic

VERILATOR ?= verilator
TOP ?= board_ctrl_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
EXTRA_FLAGS ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/board_ctrl_pkg.sv ====
package board_ctrl_pkg;

	// ======================================================================
	// board level widths
	// ======================================================================

	localparam int unsigned num_keys = 2; // push buttons on the board
	localparam int unsigned num_switches = 4; // slide switches
	localparam int unsigned led_pio_width = 7; // leds owned by the processor
	localparam int unsigned stm_event_width = 28; // trace event port width

	// unused top of the trace event word
	localparam int unsigned stm_reserved_width =
		stm_event_width - num_switches - led_pio_width - num_keys;

	// ======================================================================
	// vector types
	// ======================================================================

	typedef logic [num_keys-1:0] key_t; // active low, 1 = released
	typedef logic [num_switches-1:0] sw_t; // raw switch levels
	typedef logic [led_pio_width-1:0] led_pio_t; // maps onto led[7:1]

	// reset request bundle, cold sits in bit 0
	// same layout for the request levels and the active-low outputs
	typedef struct packed {
		logic debug; // debug reset, bit 2
		logic warm; // warm reset, bit 1
		logic cold; // cold reset, bit 0
	} reset_req_t;

	// trace event word, msb first
	typedef struct packed {
		logic [stm_reserved_width-1:0] reserved; // tied to zero
		sw_t sw; // bits 12:9
		led_pio_t led_pio; // bits 8:2
		key_t keys; // debounced keys, bits 1:0
	} stm_events_t;

	// ======================================================================
	// fsm encodings
	// ======================================================================

	// reset request pulser
	typedef enum logic {
		pulse_idle = 1'b0, // waiting for a rising edge
		pulse_active = 1'b1 // pulse being driven
	} pulse_state_e;

endpackage

// ==== hw/board_ctrl_top.sv ====
`timescale 1ns/1ps

module board_ctrl_top
	import board_ctrl_pkg::*;
#(
	parameter int unsigned debounce_cycles = 50000, // key filter window
	parameter int unsigned blink_half_period = 25000000, // heartbeat half period
	parameter int unsigned cold_pulse_cycles = 6, // cold reset pulse width
	parameter int unsigned warm_pulse_cycles = 2, // warm reset pulse width
	parameter int unsigned debug_pulse_cycles = 32 // debug reset pulse width
)
(
	input logic fpga_clk_50,
	input logic hps_fpga_reset_n, // from the processor, active low
	input key_t key, // push buttons, active low
	input sw_t sw, // slide switches
	input led_pio_t led_pio, // processor led word
	input reset_req_t reset_req, // reset request levels
	output logic [7:0] led, // board leds
	output key_t key_debounced, // filtered buttons
	output stm_events_t stm_hw_events, // trace event word
	output reset_req_t f2h_reset_n // reset requests to the processor
);

	reset_req_t req_pulse; // active high pulses from the pulsers
	logic heartbeat; // led[0]

	// ======================================================================
	// key filtering
	// ======================================================================

	key_debounce #(
		.width(num_keys),
		.debounce_cycles(debounce_cycles)
	) i_key_debounce (
		.fpga_clk_50(fpga_clk_50),
		.hps_fpga_reset_n(hps_fpga_reset_n),
		.key(key),
		.key_debounced(key_debounced)
	);

	// ======================================================================
	// reset request pulsers
	// ======================================================================

	reset_req_pulser #(
		.pulse_cycles(cold_pulse_cycles)
	) i_pulse_cold (
		.fpga_clk_50(fpga_clk_50),
		.hps_fpga_reset_n(hps_fpga_reset_n),
		.req(reset_req.cold),
		.pulse(req_pulse.cold)
	);

	reset_req_pulser #(
		.pulse_cycles(warm_pulse_cycles)
	) i_pulse_warm (
		.fpga_clk_50(fpga_clk_50),
		.hps_fpga_reset_n(hps_fpga_reset_n),
		.req(reset_req.warm),
		.pulse(req_pulse.warm)
	);

	reset_req_pulser #(
		.pulse_cycles(debug_pulse_cycles)
	) i_pulse_debug (
		.fpga_clk_50(fpga_clk_50),
		.hps_fpga_reset_n(hps_fpga_reset_n),
		.req(reset_req.debug),
		.pulse(req_pulse.debug)
	);

	assign f2h_reset_n = ~req_pulse; // processor side is active low

	// ======================================================================
	// heartbeat and led bus
	// ======================================================================

	heartbeat_blinker #(
		.half_period(blink_half_period)
	) i_heartbeat (
		.fpga_clk_50(fpga_clk_50),
		.hps_fpga_reset_n(hps_fpga_reset_n),
		.beat(heartbeat)
	);

	assign led = {led_pio, heartbeat}; // processor word above the heartbeat

	// trace events, purely combinational
	assign stm_hw_events.reserved = '0;
	assign stm_hw_events.sw = sw;
	assign stm_hw_events.led_pio = led_pio;
	assign stm_hw_events.keys = key_debounced; // filtered, not raw pins

endmodule

// ==== hw/heartbeat_blinker.sv ====
`timescale 1ns/1ps

module heartbeat_blinker
#(
	parameter int unsigned half_period = 25000000 // 0.5 s at 50 MHz
)
(
	input logic fpga_clk_50,
	input logic hps_fpga_reset_n,
	output logic beat // heartbeat led level
);

	// counter runs 0 .. half_period-1
	localparam int unsigned cnt_w = $clog2(half_period + 1);
	localparam logic [cnt_w-1:0] cnt_wrap = cnt_w'(half_period - 1);

	logic [cnt_w-1:0] div_cnt; // clock divider

	// ======================================================================
	// divider
	// ======================================================================

	// first toggle lands half_period cycles after reset release
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			div_cnt <= '0;
			beat <= 1'b0; // led off after reset
		end
		else if (div_cnt == cnt_wrap)
		begin
			div_cnt <= '0; // wrap
			beat <= ~beat; // toggle on every wrap
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

// ==== hw/key_debounce.sv ====
`timescale 1ns/1ps

module key_debounce
	import board_ctrl_pkg::*;
#(
	parameter int unsigned width = num_keys, // number of keys to filter
	parameter int unsigned debounce_cycles = 50000 // 1 ms at 50 MHz
)
(
	input logic fpga_clk_50,
	input logic hps_fpga_reset_n,
	input key_t key, // raw button pins, active low
	output key_t key_debounced // filtered levels
);

	// counter must hold debounce_cycles-1
	localparam int unsigned cnt_w = $clog2(debounce_cycles + 1);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

	key_t key_meta; // first sync stage, may go metastable
	key_t key_sync; // second sync stage, safe to use
	logic [cnt_w-1:0] stable_cnt [width]; // cycles the new level has held

	// ======================================================================
	// two-flop synchronizer
	// ======================================================================

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			key_meta <= '1; // released
			key_sync <= '1;
		end
		else
		begin
			key_meta <= key; // async pins
			key_sync <= key_meta;
		end
	end

	// ======================================================================
	// per-key stability counters
	// ======================================================================

	// A key only changes its output once the synchronized level has
	// disagreed with it on every cycle of the window. Any bounce back to
	// the old level starts the window over.
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			key_debounced <= '1; // keys released after reset
			for (int i = 0; i < width; i++)
			begin
				stable_cnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < width; i++)
			begin
				if (key_sync[i] == key_debounced[i])
				begin
					stable_cnt[i] <= '0; // no change pending
				end
				else if (stable_cnt[i] == cnt_last)
				begin
					key_debounced[i] <= key_sync[i]; // held long enough
					stable_cnt[i] <= '0;
				end
				else
				begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1; // still waiting
				end
			end
		end
	end

endmodule

// ==== hw/reset_req_pulser.sv ====
`timescale 1ns/1ps

module reset_req_pulser
	import board_ctrl_pkg::*;
#(
	parameter int unsigned pulse_cycles = 6 // width of the output pulse
)
(
	input logic fpga_clk_50,
	input logic hps_fpga_reset_n,
	input logic req, // request level, active high
	output logic pulse // fixed width pulse, active high
);

	// down-counter holds pulse_cycles-1 at most
	localparam int unsigned cnt_w = $clog2(pulse_cycles + 1);
	localparam logic [cnt_w-1:0] cnt_load = cnt_w'(pulse_cycles - 1);

	logic req_q; // registered request
	logic req_q_d; // previous registered request
	logic req_rise; // one cycle on a 0->1 of req_q
	pulse_state_e state;
	logic [cnt_w-1:0] remain; // cycles left after this one

	// ======================================================================
	// edge detect
	// ======================================================================

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			req_q <= 1'b0;
			req_q_d <= 1'b0;
		end
		else
		begin
			req_q <= req; // capture the level
			req_q_d <= req_q; // history for the edge
		end
	end

	assign req_rise = req_q & ~req_q_d; // level only, no handshake

	// ======================================================================
	// pulse fsm
	// ======================================================================

	// The pulse starts on the clock after req_q rises, which is the second
	// rising edge after the request itself. The counter is loaded with
	// pulse_cycles-1 because the load cycle already counts as active.
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			state <= pulse_idle; // reset always cancels a pulse
			remain <= '0;
		end
		else
		begin
			case (state)
				pulse_idle:
				begin
					if (req_rise)
					begin
						state <= pulse_active; // start pulse
						remain <= cnt_load;
					end
				end
				pulse_active:
				begin
					// req_rise ignored here, no retrigger
					if (remain == '0)
					begin
						state <= pulse_idle; // last cycle done
					end
					else
					begin
						remain <= remain - 1'b1;
					end
				end
				default:
				begin
					state <= pulse_idle;
				end
			endcase
		end
	end

	assign pulse = (state == pulse_active); // straight from the state flop

endmodule

// ==== sources.f ====
hw/board_ctrl_pkg.sv
hw/key_debounce.sv
hw/reset_req_pulser.sv
hw/heartbeat_blinker.sv
hw/board_ctrl_top.sv
verification/board_ctrl_sva.sv
verification/board_ctrl_checker.sv
verification/board_ctrl_tb.sv

// ==== verification/board_ctrl_checker.sv ====
`timescale 1ns/1ps

module board_ctrl_checker
	import board_ctrl_pkg::*;
#(
	parameter int unsigned blink_half_period = 20,
	parameter int unsigned cold_pulse_cycles = 6,
	parameter int unsigned warm_pulse_cycles = 2,
	parameter int unsigned debug_pulse_cycles = 5
)
(
	input logic fpga_clk_50,
	input logic hps_fpga_reset_n,
	input sw_t sw,
	input led_pio_t led_pio,
	input reset_req_t reset_req,
	input logic [7:0] led,
	input key_t key_debounced,
	input stm_events_t stm_hw_events,
	input reset_req_t f2h_reset_n,
	output int error_count // total failed checks
);

	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0; // error count when the current test began
	int unsigned cyc = 0; // cycles since reset release
	int unsigned rem [3]; // expected pulse cycles left, per field
	logic [2:0] pend = '0; // pulse due on the next cycle
	logic [2:0] req_last = '0;
	logic [2:0] req_bits;
	logic [2:0] exp_n; // expected active-low outputs
	logic active;

	initial error_count = 0;

	task automatic compare_value(input string sig_name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (exp_val !== act_val)
		begin
			$display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
				$time, sig_name, exp_val, act_val);
			error_count++;
		end
	endtask

	task automatic fail_plain(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic test_done(input string name);
		tests_run++;
		if (error_count == errors_at_start)
			$display("test %0d %s: pass", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", tests_run, name,
				error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	task automatic summary();
		$display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, error_count);
	endtask

	function automatic int unsigned pulse_width(input int idx);
		if (idx == 0) return cold_pulse_cycles;
		else if (idx == 1) return warm_pulse_cycles;
		else return debug_pulse_cycles;
	endfunction

	// ======================================================================
	// continuous model, sampled mid cycle
	// ======================================================================

	always @(posedge fpga_clk_50)
	begin
		#10; // registered outputs settled, inputs not yet changed
		req_bits = reset_req;
		if (!hps_fpga_reset_n)
		begin
			cyc = 0;
			pend = '0;
			req_last = '0;
			for (int i = 0; i < 3; i++) rem[i] = 0;
		end
		else
		begin
			cyc++;
			compare_value("led[0]", (cyc / blink_half_period) % 2, led[0]); // heartbeat
			compare_value("led[7:1]", led_pio, led[7:1]);
			compare_value("stm_hw_events.sw", sw, stm_hw_events.sw);
			compare_value("stm_hw_events.led_pio", led_pio, stm_hw_events.led_pio);
			compare_value("stm_hw_events.keys", key_debounced, stm_hw_events.keys);
			compare_value("stm_hw_events.reserved", 0, stm_hw_events.reserved);
			for (int i = 0; i < 3; i++)
			begin
				if (pend[i])
				begin
					rem[i] = pulse_width(i); // pulse begins this cycle
					pend[i] = 1'b0;
				end
				active = (rem[i] > 0);
				exp_n[i] = ~active;
				if (req_bits[i] && !req_last[i] && !active)
					pend[i] = 1'b1; // edge while busy is dropped
				if (active)
					rem[i]--;
			end
			compare_value("f2h_reset_n", exp_n, f2h_reset_n);
			req_last = req_bits;
		end
	end

endmodule

// ==== verification/board_ctrl_sva.sv ====
`timescale 1ns/1ps

module board_ctrl_sva
#(
	parameter int unsigned limit = 6, // pulse width or half period
	parameter bit is_pulse = 1'b1 // 1 = pulser, 0 = heartbeat
)
(
	input logic clk,
	input logic rst_n,
	input logic sig // watched level
);

	int unsigned run_len; // samples spent at the current level
	logic last_sig; // level seen on the previous sample

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run_len <= 0;
			last_sig <= 1'b0;
		end
		else
		begin
			if (sig != last_sig)
				run_len <= 1; // new level starts
			else
				run_len <= run_len + 1;
			last_sig <= sig;
		end
	end

	// ======================================================================
	// properties
	// ======================================================================

	if (is_pulse)
	begin : g_pulse
		// high samples counted when the pulse drops
		a_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
			$fell(sig) |-> run_len == limit)
			else $error("pulse width differs from pulse_cycles");
		a_pulse_bound: assert property (@(posedge clk) disable iff (!rst_n)
			(sig && last_sig) |-> run_len < limit)
			else $error("pulse held longer than pulse_cycles");
	end
	else
	begin : g_beat
		a_beat_period: assert property (@(posedge clk) disable iff (!rst_n)
			$changed(sig) |-> run_len == limit)
			else $error("heartbeat toggled off its half period");
	end

endmodule

bind reset_req_pulser board_ctrl_sva #(.limit(pulse_cycles), .is_pulse(1'b1)) i_sva (
	.clk(fpga_clk_50), .rst_n(hps_fpga_reset_n), .sig(pulse));

bind heartbeat_blinker board_ctrl_sva #(.limit(half_period), .is_pulse(1'b0)) i_sva (
	.clk(fpga_clk_50), .rst_n(hps_fpga_reset_n), .sig(beat));

// ==== verification/board_ctrl_tb.sv ====
`timescale 1ns/1ps

module board_ctrl_tb
	import board_ctrl_pkg::*;
;

	localparam int unsigned deb = 8; // debounce window
	localparam int unsigned half = 20; // heartbeat half period
	localparam int num_rows = 17;

	typedef enum logic [2:0] {
		row_reset, row_key_level, row_key_glitch, row_req_edge, row_sw_led, row_beat
	} row_kind_e;

	typedef struct packed {
		row_kind_e kind;
		logic [7:0] value; // key level, request mask
		logic [7:0] expected; // latency, width or period
		logic retrig; // second edge inside the pulse
	} row_t;

	logic fpga_clk_50 = 1'b0;
	logic hps_fpga_reset_n = 1'b0;
	key_t key = '1;
	sw_t sw = '0;
	led_pio_t led_pio = '0;
	reset_req_t reset_req = '0;
	logic [7:0] led;
	key_t key_debounced;
	stm_events_t stm_hw_events;
	reset_req_t f2h_reset_n;
	int error_count;
	row_t rows [num_rows];

	always #20 fpga_clk_50 = ~fpga_clk_50; // 40 ns period

	board_ctrl_top #(.debounce_cycles(deb), .blink_half_period(half), .cold_pulse_cycles(6),
		.warm_pulse_cycles(2), .debug_pulse_cycles(5)) i_dut (.*);

	board_ctrl_checker #(.blink_half_period(half), .cold_pulse_cycles(6),
		.warm_pulse_cycles(2), .debug_pulse_cycles(5)) i_chk (.*);

	task automatic apply_key_level(input key_t v);
		int n;
		n = 0;
		@(negedge fpga_clk_50);
		key = v;
		while (key_debounced !== v && n < deb + 4)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		if (key_debounced !== v)
			i_chk.fail_plain("key_debounced did not follow the key in time");
		else if (n < deb + 2)
			i_chk.compare_value("key latency", deb + 2, n); // too early
	endtask

	task automatic apply_key_glitch(input key_t v, input int len);
		key_t held;
		held = key;
		@(negedge fpga_clk_50);
		key = v;
		repeat (len) @(negedge fpga_clk_50);
		key = held; // back to the stable level
		repeat (deb + 6)
		begin
			@(negedge fpga_clk_50);
			i_chk.compare_value("key_debounced", held, key_debounced);
		end
	endtask

	task automatic apply_req_edge(input logic [2:0] mask, input int width, input logic retrig);
		int n;
		int low;
		n = 0;
		low = 0;
		@(negedge fpga_clk_50);
		reset_req = reset_req | mask;
		while ((f2h_reset_n & mask) != 0 && n < 4) // wait for the pulse
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		if ((f2h_reset_n & mask) != 0)
			i_chk.fail_plain("reset request produced no pulse");
		else
		begin
			i_chk.compare_value("pulse start delay", 2, n);
			while ((f2h_reset_n & mask) == 0 && low < width + 4)
			begin
				low++;
				if (retrig && low == 2)
					reset_req = reset_req & ~mask;
				if (retrig && low == 3)
					reset_req = reset_req | mask; // ignored edge
				@(negedge fpga_clk_50);
			end
			i_chk.compare_value("f2h_reset_n pulse width", width, low);
			repeat (12)
			begin
				@(negedge fpga_clk_50);
				i_chk.compare_value("f2h_reset_n after pulse", mask, f2h_reset_n & mask);
			end
		end
		reset_req = reset_req & ~mask;
		repeat (2) @(negedge fpga_clk_50);
	endtask

	task automatic apply_sw_led();
		sw_t s;
		led_pio_t l;
		s = sw_t'($urandom);
		l = led_pio_t'($urandom);
		@(negedge fpga_clk_50);
		sw = s;
		led_pio = l;
		#10; // still in the low phase, no clock edge since the drive
		i_chk.compare_value("led[7:1]", l, led[7:1]);
		i_chk.compare_value("stm_hw_events", {15'd0, s, l, key_debounced}, stm_hw_events);
	endtask

	task automatic measure_beat(input int period);
		int n;
		logic b;
		n = 0;
		b = led[0];
		while (led[0] === b && n < 2 * period + 2) // align to a toggle
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		b = led[0];
		n = 0;
		while (led[0] === b && n < period + 2)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		if (led[0] === b)
			i_chk.fail_plain("heartbeat stopped toggling");
		else
			i_chk.compare_value("led[0] half period", period, n);
	endtask

	initial
	begin
		void'($urandom(32'haa2d_562d)); // one seed for the whole run
		rows[0] = '{row_reset, 8'h00, 8'd0, 1'b0};
		rows[1] = '{row_key_level, 8'h02, 8'd0, 1'b0}; // key0 pressed
		rows[2] = '{row_key_level, 8'h03, 8'd0, 1'b0};
		rows[3] = '{row_key_glitch, 8'h01, 8'd5, 1'b0};
		rows[4] = '{row_key_level, 8'h00, 8'd0, 1'b0};
		rows[5] = '{row_key_glitch, 8'h03, 8'd4, 1'b0};
		rows[6] = '{row_key_level, 8'h03, 8'd0, 1'b0};
		rows[7] = '{row_req_edge, 8'h01, 8'd6, 1'b0}; // cold
		rows[8] = '{row_req_edge, 8'h02, 8'd2, 1'b0}; // warm
		rows[9] = '{row_req_edge, 8'h04, 8'd5, 1'b0}; // debug
		rows[10] = '{row_req_edge, 8'h01, 8'd6, 1'b1};
		rows[11] = '{row_req_edge, 8'h04, 8'd5, 1'b1};
		for (int i = 12; i < 16; i++)
			rows[i] = '{row_sw_led, 8'h00, 8'd0, 1'b0};
		rows[16] = '{row_beat, 8'h00, 8'd20, 1'b0};
		repeat (2) @(negedge fpga_clk_50);
		hps_fpga_reset_n = 1'b1;
		for (int i = 0; i < num_rows; i++)
		begin
			case (rows[i].kind)
				row_reset:
				begin
					i_chk.compare_value("key_debounced", 3, key_debounced);
					i_chk.compare_value("led[0]", 0, led[0]);
					i_chk.compare_value("f2h_reset_n", 7, f2h_reset_n);
				end
				row_key_level: apply_key_level(key_t'(rows[i].value));
				row_key_glitch: apply_key_glitch(key_t'(rows[i].value), rows[i].expected);
				row_req_edge: apply_req_edge(rows[i].value[2:0], rows[i].expected,
					rows[i].retrig);
				row_sw_led: apply_sw_led();
				default: measure_beat(rows[i].expected);
			endcase
			i_chk.test_done(rows[i].kind.name());
		end
		i_chk.summary();
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
